/* include/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ==================================================
// Core geometry
// ==================================================
`define CORE_XLEN           32
`define CORE_NREGS          32

// Fetch start and handler entry
`define CORE_RESET_PC       32'h0000_0000
`define CORE_TRAP_VECTOR    32'h0000_0100

// ==================================================
// Machine CSR numbers
// ==================================================
`define CORE_CSR_MEPC       12'h341
`define CORE_CSR_MCAUSE     12'h342
`define CORE_CSR_MINSTRET   12'hB02

// Trap causes, top bit marks an interrupt
`define CORE_CAUSE_ILLEGAL  32'h0000_0002
`define CORE_CAUSE_EXT_IRQ  32'h8000_000B

`endif

/* hdl/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    // ==================================================
    // Decoded operations
    // ==================================================
    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_LUI,
        OP_SW,
        OP_CSRR,
        OP_MRET,
        OP_ILLEGAL
    } op_e;

    // Trap sequencing
    typedef enum logic [1:0] {
        TS_RUN,
        TS_DRAIN,
        TS_REDIRECT
    } trap_state_e;

    // ==================================================
    // Grouped payloads
    // ==================================================

    // Instruction word with the address it was read from
    typedef struct packed {
        logic [31:0]            instr;
        logic [`CORE_XLEN-1:0]  pc;
    } fetch_beat_t;

    // Work item handed from decode to execute
    typedef struct packed {
        op_e                    op;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [31:0]            imm;
        logic [11:0]            csr;
        logic [`CORE_XLEN-1:0]  pc;
    } decoded_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]  addr;
        logic [`CORE_XLEN-1:0]  data;
    } store_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`CORE_XLEN-1:0]  pc;
    } redirect_t;

endpackage

/* hdl/fetch_decode.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module fetch_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_pkg::redirect_t     redirect,
    output logic                    imem_req,
    output logic [`CORE_XLEN-1:0]   imem_addr,
    input  logic                    imem_valid,
    input  core_pkg::fetch_beat_t   imem_beat,
    output logic                    imem_ready,
    output logic                    dec_valid,
    output core_pkg::decoded_t      dec_item,
    input  logic                    dec_ready
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0]  expect_pc;
    logic                   fetch_on;
    logic                   beat_keep;
    logic [31:0]            instr;
    decoded_t               dec_next;

    // ==================================================
    // Fetch side
    // ==================================================
    assign imem_req   = redirect.valid;
    // Outside a request this is the next address decode waits for
    assign imem_addr  = redirect.valid ? redirect.pc : expect_pc;
    assign imem_ready = fetch_on && (!dec_valid || dec_ready);

    // Beats from before a redirect carry the wrong address
    assign beat_keep  = imem_valid && imem_ready && !redirect.valid &&
                        (imem_beat.pc == expect_pc);

    // ==================================================
    // Decode
    // ==================================================
    assign instr = imem_beat.instr;

    always_comb begin
        dec_next.op  = OP_ILLEGAL;
        dec_next.rd  = instr[11:7];
        dec_next.rs1 = instr[19:15];
        dec_next.rs2 = instr[24:20];
        dec_next.imm = {{20{instr[31]}}, instr[31:20]};
        dec_next.csr = instr[31:20];
        dec_next.pc  = imem_beat.pc;
        case (instr[6:0])
            7'b0010011: if (instr[14:12] == 3'b000) dec_next.op = OP_ADDI;
            7'b0110011: begin
                case ({instr[31:25], instr[14:12]})
                    10'b0000000_000: dec_next.op = OP_ADD;
                    10'b0100000_000: dec_next.op = OP_SUB;
                    10'b0000000_111: dec_next.op = OP_AND;
                    10'b0000000_110: dec_next.op = OP_OR;
                    10'b0000000_100: dec_next.op = OP_XOR;
                    default:         dec_next.op = OP_ILLEGAL;
                endcase
            end
            7'b0110111: begin
                dec_next.op  = OP_LUI;
                dec_next.imm = {instr[31:12], 12'h000};
            end
            7'b0100011: begin
                if (instr[14:12] == 3'b010) dec_next.op = OP_SW;
                dec_next.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            7'b1110011: begin
                if (instr == 32'h3020_0073) begin
                    dec_next.op = OP_MRET;
                end else if (instr[14:12] == 3'b010 && instr[19:15] == 5'd0) begin
                    // CSRRS as a plain read
                    dec_next.op = OP_CSRR;
                end
            end
            default: dec_next.op = OP_ILLEGAL;
        endcase
    end

    // ==================================================
    // Holding register
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_on  <= 1'b0;
            dec_valid <= 1'b0;
            expect_pc <= `CORE_RESET_PC;
        end else if (redirect.valid) begin
            fetch_on  <= 1'b1;
            dec_valid <= 1'b0;
            expect_pc <= redirect.pc;
        end else if (beat_keep) begin
            dec_valid <= 1'b1;
            expect_pc <= expect_pc + `CORE_XLEN'(4);
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_keep) begin
            dec_item <= dec_next;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    output logic [`CORE_XLEN-1:0]   rs1_data,
    output logic [`CORE_XLEN-1:0]   rs2_data,
    input  logic                    wr_en,
    input  logic [4:0]              wr_addr,
    input  logic [`CORE_XLEN-1:0]   wr_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    // x0 is cleared at reset and never written, so it reads zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module execute_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    dec_valid,
    input  core_pkg::decoded_t      dec_item,
    output logic                    dec_ready,
    input  logic                    exec_hold,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    input  logic [`CORE_XLEN-1:0]   rs1_data,
    input  logic [`CORE_XLEN-1:0]   rs2_data,
    output logic                    wr_en,
    output logic [4:0]              wr_addr,
    output logic [`CORE_XLEN-1:0]   wr_data,
    input  logic [`CORE_XLEN-1:0]   csr_mepc,
    input  logic [`CORE_XLEN-1:0]   csr_mcause,
    input  logic [`CORE_XLEN-1:0]   minstret,
    output logic                    store_valid,
    output core_pkg::store_req_t    store_req,
    input  logic                    store_ready,
    output logic                    retire,
    output logic                    illegal,
    output logic [`CORE_XLEN-1:0]   illegal_pc,
    output logic                    mret_seen,
    output logic                    busy
);
    import core_pkg::*;

    logic                   accept;
    logic                   take_store;
    logic [`CORE_XLEN-1:0]  csr_rdata;

    // A pending store blocks the next item
    assign dec_ready  = !exec_hold && !store_valid;
    assign accept     = dec_valid && dec_ready;
    assign take_store = accept && dec_item.op == OP_SW;
    assign busy       = store_valid;

    assign rs1_addr = dec_item.rs1;
    assign rs2_addr = dec_item.rs2;

    always_comb begin
        case (dec_item.csr)
            `CORE_CSR_MEPC:     csr_rdata = csr_mepc;
            `CORE_CSR_MCAUSE:   csr_rdata = csr_mcause;
            `CORE_CSR_MINSTRET: csr_rdata = minstret;
            default:            csr_rdata = '0;
        endcase
    end

    // ==================================================
    // ALU and write back
    // ==================================================
    always_comb begin
        wr_en = accept;
        case (dec_item.op)
            OP_ADDI: wr_data = rs1_data + dec_item.imm;
            OP_ADD:  wr_data = rs1_data + rs2_data;
            OP_SUB:  wr_data = rs1_data - rs2_data;
            OP_AND:  wr_data = rs1_data & rs2_data;
            OP_OR:   wr_data = rs1_data | rs2_data;
            OP_XOR:  wr_data = rs1_data ^ rs2_data;
            OP_LUI:  wr_data = dec_item.imm;
            OP_CSRR: wr_data = csr_rdata;
            default: begin
                wr_en   = 1'b0;
                wr_data = '0;
            end
        endcase
    end
    assign wr_addr = dec_item.rd;

    // Trap reporting
    assign illegal    = accept && dec_item.op == OP_ILLEGAL;
    assign illegal_pc = dec_item.pc;
    assign mret_seen  = accept && dec_item.op == OP_MRET;

    // Stores retire on the transfer, not on acceptance
    assign retire = (accept && dec_item.op != OP_SW && dec_item.op != OP_ILLEGAL) ||
                    (store_valid && store_ready);

    // ==================================================
    // Store port
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_valid <= 1'b0;
        end else if (take_store) begin
            store_valid <= 1'b1;
        end else if (store_ready) begin
            store_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_store) begin
            store_req.addr <= rs1_data + dec_item.imm;
            store_req.data <= rs2_data;
        end
    end

endmodule

/* hdl/trap_ctrl.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module trap_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    irq,
    input  logic                    illegal,
    input  logic [`CORE_XLEN-1:0]   illegal_pc,
    input  logic                    mret_seen,
    input  logic                    busy,
    input  logic                    dec_valid,
    input  logic [`CORE_XLEN-1:0]   dec_pc,
    input  logic [`CORE_XLEN-1:0]   fetch_pc,
    output logic                    exec_hold,
    output core_pkg::redirect_t     redirect,
    output logic [`CORE_XLEN-1:0]   csr_mepc,
    output logic [`CORE_XLEN-1:0]   csr_mcause
);
    import core_pkg::*;

    trap_state_e            state;
    logic                   booted;
    logic                   irq_mask;
    logic                   take_irq;
    logic [`CORE_XLEN-1:0]  target_pc;

    // Illegal and MRET in the same cycle win over the interrupt
    assign take_irq = booted && irq && !irq_mask && !busy && !illegal && !mret_seen;

    assign exec_hold      = (state != TS_RUN);
    assign redirect.valid = (state == TS_REDIRECT);
    assign redirect.pc    = target_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= TS_RUN;
            booted     <= 1'b0;
            irq_mask   <= 1'b0;
            target_pc  <= `CORE_RESET_PC;
            csr_mepc   <= '0;
            csr_mcause <= '0;
        end else begin
            case (state)
                TS_RUN: begin
                    if (!booted) begin
                        // First request out of reset
                        state     <= TS_REDIRECT;
                        booted    <= 1'b1;
                        target_pc <= `CORE_RESET_PC;
                    end else if (illegal) begin
                        state      <= TS_REDIRECT;
                        irq_mask   <= 1'b1;
                        target_pc  <= `CORE_TRAP_VECTOR;
                        csr_mepc   <= illegal_pc;
                        csr_mcause <= `CORE_CAUSE_ILLEGAL;
                    end else if (mret_seen) begin
                        state     <= TS_REDIRECT;
                        irq_mask  <= 1'b0;
                        target_pc <= csr_mepc;
                    end else if (take_irq) begin
                        state <= TS_DRAIN;
                    end
                end
                TS_DRAIN: begin
                    // Execute is held, so the held item is the resume point
                    state      <= TS_REDIRECT;
                    irq_mask   <= 1'b1;
                    target_pc  <= `CORE_TRAP_VECTOR;
                    csr_mepc   <= dec_valid ? dec_pc : fetch_pc;
                    csr_mcause <= `CORE_CAUSE_EXT_IRQ;
                end
                default: state <= TS_RUN;
            endcase
        end
    end

endmodule

/* hdl/retire_counter.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module retire_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    retire,
    output logic [`CORE_XLEN-1:0]   minstret
);

    // Wraps silently at the top
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            minstret <= '0;
        end else if (retire) begin
            minstret <= minstret + `CORE_XLEN'(1);
        end
    end

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    imem_req,
    output logic [`CORE_XLEN-1:0]   imem_addr,
    input  logic                    imem_valid,
    input  core_pkg::fetch_beat_t   imem_beat,
    output logic                    imem_ready,
    input  logic                    irq,
    output logic                    store_valid,
    output core_pkg::store_req_t    store_req,
    input  logic                    store_ready
);
    import core_pkg::*;

    // ==================================================
    // Internal nets
    // ==================================================
    redirect_t              redirect;
    logic                   dec_valid;
    logic                   dec_ready;
    decoded_t               dec_item;
    logic                   exec_hold;

    logic [4:0]             rs1_addr;
    logic [4:0]             rs2_addr;
    logic [`CORE_XLEN-1:0]  rs1_data;
    logic [`CORE_XLEN-1:0]  rs2_data;
    logic                   wr_en;
    logic [4:0]             wr_addr;
    logic [`CORE_XLEN-1:0]  wr_data;

    logic [`CORE_XLEN-1:0]  csr_mepc;
    logic [`CORE_XLEN-1:0]  csr_mcause;
    logic [`CORE_XLEN-1:0]  minstret;
    logic                   retire;
    logic                   illegal;
    logic [`CORE_XLEN-1:0]  illegal_pc;
    logic                   mret_seen;
    logic                   busy;

    // ==================================================
    // Units
    // ==================================================
    fetch_decode u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_beat  (imem_beat),
        .imem_ready (imem_ready),
        .dec_valid  (dec_valid),
        .dec_item   (dec_item),
        .dec_ready  (dec_ready)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    execute_unit u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid   (dec_valid),
        .dec_item    (dec_item),
        .dec_ready   (dec_ready),
        .exec_hold   (exec_hold),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .csr_mepc    (csr_mepc),
        .csr_mcause  (csr_mcause),
        .minstret    (minstret),
        .store_valid (store_valid),
        .store_req   (store_req),
        .store_ready (store_ready),
        .retire      (retire),
        .illegal     (illegal),
        .illegal_pc  (illegal_pc),
        .mret_seen   (mret_seen),
        .busy        (busy)
    );

    // Outside a request imem_addr is the expected fetch PC
    trap_ctrl u_trap (
        .clk        (clk),
        .rst_n      (rst_n),
        .irq        (irq),
        .illegal    (illegal),
        .illegal_pc (illegal_pc),
        .mret_seen  (mret_seen),
        .busy       (busy),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_item.pc),
        .fetch_pc   (imem_addr),
        .exec_hold  (exec_hold),
        .redirect   (redirect),
        .csr_mepc   (csr_mepc),
        .csr_mcause (csr_mcause)
    );

    retire_counter u_minstret (
        .clk      (clk),
        .rst_n    (rst_n),
        .retire   (retire),
        .minstret (minstret)
    );

endmodule

/* dv/core_sva.sv */
`timescale 1ns/1ps

module core_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 imem_req,
    input logic                 imem_ready,
    input logic                 store_valid,
    input logic                 store_ready,
    input core_pkg::store_req_t store_req
);

    int fail_count = 0;

    // A waiting store keeps its request and payload
    store_hold: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid && !store_ready |=> store_valid && $stable(store_req))
        else begin
            $error("store request changed while waiting");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !store_valid && !imem_ready)
        else begin
            $error("store_valid or imem_ready high in reset");
            fail_count++;
        end

    // Fetch restart is a single pulse
    req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req |=> !imem_req)
        else begin
            $error("imem_req longer than one cycle");
            fail_count++;
        end

endmodule

bind core_top core_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .imem_req    (imem_req),
    .imem_ready  (imem_ready),
    .store_valid (store_valid),
    .store_ready (store_ready),
    .store_req   (store_req)
);

/* dv/core_tb.sv */
`timescale 1ns/1ps

`include "core_cfg.svh"

module core_tb;
    import core_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   imem_req;
    logic [`CORE_XLEN-1:0]  imem_addr;
    logic                   imem_valid;
    fetch_beat_t            imem_beat;
    logic                   imem_ready;
    logic                   irq;
    logic                   store_valid;
    store_req_t             store_req;
    logic                   store_ready;

    logic [31:0]    prog [128];
    logic [31:0]    exp_addr [$];
    logic [31:0]    exp_data [$];
    logic [31:0]    exp_pc [$];
    logic [31:0]    hnd_data [$];
    int             hnd_at [$];
    logic [31:0]    mem_pc;
    logic [31:0]    patch_addr;
    integer         seed = 32'h1a1;
    int             cycles = 0;
    int             errors = 0;
    int             fails = 0;
    int             tests = 0;
    int             idx;
    int             obs_cnt;
    bit             gaps;
    bit             irq_mode;
    bit             first_req_seen;
    string          cur_name;

    core_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Instruction encoders
    // ==================================================
    function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'h13};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_lui(logic [4:0] rd, logic [19:0] u);
        return {u, rd, 7'h37};
    endfunction

    function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] off);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_csrr(logic [4:0] rd, logic [11:0] csr);
        return {csr, 5'd0, 3'b010, rd, 7'h73};
    endfunction

    // ==================================================
    // Reference model of the ISA subset
    // ==================================================
    function automatic void ref_model(int main_len);
        logic [31:0] p [128];
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] instret;
        logic [31:0] val;
        logic [31:0] a;
        logic [31:0] b;
        bit          wr;
        bit          ill;
        for (int i = 0; i < 128; i++) p[i] = prog[i];
        for (int i = 0; i < 32; i++) x[i] = '0;
        pc = `CORE_RESET_PC;
        mepc = '0;
        mcause = '0;
        instret = '0;
        for (int s = 0; s < 400; s++) begin
            if (pc < `CORE_TRAP_VECTOR && pc >= main_len * 4) break;
            ins = p[pc[8:2]];
            a = x[ins[19:15]];
            b = x[ins[24:20]];
            wr = 1'b0;
            ill = 1'b0;
            val = '0;
            case (ins[6:0])
                7'h13: begin
                    wr = (ins[14:12] == 3'b000);
                    ill = !wr;
                    val = a + {{20{ins[31]}}, ins[31:20]};
                end
                7'h33: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        default: begin
                            wr = 1'b0;
                            ill = 1'b1;
                        end
                    endcase
                end
                7'h37: begin
                    wr = 1'b1;
                    val = {ins[31:12], 12'h000};
                end
                7'h23: begin
                    if (ins[14:12] == 3'b010) begin
                        exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                        exp_data.push_back(b);
                        exp_pc.push_back(pc);
                    end else begin
                        ill = 1'b1;
                    end
                end
                7'h73: begin
                    if (ins == 32'h3020_0073) begin
                        instret++;
                        pc = mepc;
                        continue;
                    end else if (ins[14:12] == 3'b010 && ins[19:15] == 5'd0) begin
                        wr = 1'b1;
                        case (ins[31:20])
                            `CORE_CSR_MEPC:     val = mepc;
                            `CORE_CSR_MCAUSE:   val = mcause;
                            `CORE_CSR_MINSTRET: val = instret;
                            default:            val = '0;
                        endcase
                    end else begin
                        ill = 1'b1;
                    end
                end
                default: ill = 1'b1;
            endcase
            if (ill) begin
                // The memory model replaces the word before the return fetch
                mepc = pc;
                mcause = `CORE_CAUSE_ILLEGAL;
                p[pc[8:2]] = enc_addi(5'd0, 5'd0, 12'd0);
                pc = `CORE_TRAP_VECTOR;
                continue;
            end
            if (wr && ins[11:7] != 5'd0) x[ins[11:7]] = val;
            instret++;
            pc = pc + 4;
        end
    endfunction

    // ==================================================
    // Memory model and input drive
    // ==================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_pc = `CORE_RESET_PC;
        end else if (imem_req) begin
            if (!first_req_seen) begin
                assert (imem_addr == `CORE_RESET_PC) else begin
                    errors++;
                    $display("ERROR %s: first fetch expected %h actual %h",
                             cur_name, `CORE_RESET_PC, imem_addr);
                end
                first_req_seen = 1'b1;
            end
            if (imem_addr == patch_addr) prog[imem_addr[8:2]] = enc_addi(5'd0, 5'd0, 12'd0);
            mem_pc = imem_addr;
        end else if (imem_valid && imem_ready) begin
            mem_pc = mem_pc + 4;
        end
    end

    always @(negedge clk) begin
        imem_valid = gaps ? (($random(seed) & 3) != 0) : 1'b1;
        store_ready = gaps ? (($random(seed) & 3) == 0) : 1'b1;
        imem_beat.instr = prog[mem_pc[8:2]];
        imem_beat.pc = mem_pc;
        if (hnd_data.size() > 0) irq = 1'b0;
    end

    // Store monitor and comparison
    always @(posedge clk) begin
        if (rst_n && store_valid && store_ready) begin
            obs_cnt++;
            if (irq_mode && store_req.addr >= 32'h400) begin
                hnd_data.push_back(store_req.data);
                hnd_at.push_back(idx);
            end else begin
                assert (idx < exp_addr.size()) else begin
                    errors++;
                    $display("%s: a store to %h was not expected", cur_name, store_req.addr);
                end
                if (idx < exp_addr.size()) begin
                    assert (store_req == {exp_addr[idx], exp_data[idx]}) else begin
                        errors++;
                        $display("ERROR %s: store %0d expected %h:%h actual %h:%h", cur_name,
                                 idx, exp_addr[idx], exp_data[idx], store_req.addr,
                                 store_req.data);
                    end
                    idx++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("Run stopped at %0d cycles, stores did not complete in %s",
                     cycles, cur_name);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ==================================================
    // Programs
    // ==================================================
    task automatic load_base();
        for (int i = 0; i < 128; i++) prog[i] = enc_addi(5'd0, 5'd0, 12'(i));
        // Handler stores mcause then mepc and returns
        prog[64] = enc_csrr(5'd20, `CORE_CSR_MCAUSE);
        prog[65] = enc_csrr(5'd21, `CORE_CSR_MEPC);
        prog[66] = enc_sw(5'd20, 5'd0, 12'h400);
        prog[67] = enc_sw(5'd21, 5'd0, 12'h404);
        prog[68] = 32'h3020_0073;
        patch_addr = 32'hffff_ffff;
    endtask

    task automatic load_arith();
        load_base();
        prog[0] = enc_lui(5'd1, 20'h12345);
        prog[1] = enc_addi(5'd1, 5'd1, 12'h678);
        prog[2] = enc_addi(5'd2, 5'd0, 12'hffb);
        prog[3] = enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2);
        prog[4] = enc_r(7'h20, 3'b000, 5'd4, 5'd2, 5'd1);
        prog[5] = enc_r(7'h00, 3'b111, 5'd5, 5'd1, 5'd4);
        prog[6] = enc_r(7'h00, 3'b110, 5'd6, 5'd3, 5'd2);
        prog[7] = enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd1);
        prog[8] = enc_addi(5'd0, 5'd1, 12'd7);
        prog[9] = enc_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd1);
        // Store x0 through x7 in register order
        for (int i = 0; i < 8; i++) begin
            prog[10+i] = enc_sw(5'(i), 5'd0, 12'(16 + 4*i));
        end
    endtask

    task automatic run_test(string name, int main_len, bit use_gaps, bit use_irq);
        int n_before;
        int start_err;
        int start_sva;
        @(negedge clk);
        rst_n = 1'b0;
        cur_name = name;
        gaps = use_gaps;
        irq_mode = use_irq;
        first_req_seen = 1'b0;
        start_err = errors;
        start_sva = u_dut.u_sva.fail_count;
        idx = 0;
        obs_cnt = 0;
        exp_addr.delete();
        exp_data.delete();
        exp_pc.delete();
        hnd_data.delete();
        hnd_at.delete();
        ref_model(main_len);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        if (use_irq) begin
            repeat (8) @(negedge clk);
            irq = 1'b1;
        end
        while (obs_cnt < exp_addr.size() + (use_irq ? 2 : 0)) @(posedge clk);
        repeat (16) @(posedge clk);
        assert (idx == exp_addr.size()) else begin
            errors++;
            $display("%s: some expected stores never appeared", name);
        end
        if (use_irq) begin
            assert (hnd_data.size() == 2) else begin
                errors++;
                $display("%s: handler did not store exactly twice", name);
            end
            if (hnd_data.size() == 2) begin
                assert (hnd_data[0] == `CORE_CAUSE_EXT_IRQ) else begin
                    errors++;
                    $display("ERROR %s: mcause expected %h actual %h", name,
                             `CORE_CAUSE_EXT_IRQ, hnd_data[0]);
                end
                assert (hnd_data[1] < main_len * 4 && hnd_data[1][1:0] == 2'b00) else begin
                    errors++;
                    $display("%s: mepc %h is not a main program address", name, hnd_data[1]);
                end
                n_before = 0;
                foreach (exp_pc[i]) if (exp_pc[i] < hnd_data[1]) n_before++;
                assert (hnd_at[0] == n_before && hnd_at[1] == n_before) else begin
                    errors++;
                    $display("ERROR %s: main stores before handler expected %0d actual %0d",
                             name, n_before, hnd_at[0]);
                end
            end
        end
        assert (u_dut.u_sva.fail_count == start_sva) else begin
            errors++;
            $display("%s: a bound protocol assertion failed", name);
        end
        @(negedge clk);
        irq = 1'b0;
        tests++;
        if (errors != start_err) fails++;
        $display("%-12s %s", name, (errors == start_err) ? "pass" : "fail");
    endtask

    initial begin
        rst_n = 1'b0;
        imem_valid = 1'b0;
        imem_beat = '0;
        irq = 1'b0;
        store_ready = 1'b0;
        gaps = 1'b0;
        irq_mode = 1'b0;
        load_base();

        load_arith();
        run_test("reset_start", 18, 1'b0, 1'b0);
        load_arith();
        run_test("arith_store", 18, 1'b0, 1'b0);
        load_arith();
        run_test("backpressure", 18, 1'b1, 1'b0);

        load_base();
        for (int i = 0; i < 5; i++) prog[i] = enc_addi(5'(i + 1), 5'd0, 12'(i + 9));
        prog[5] = enc_csrr(5'd9, `CORE_CSR_MINSTRET);
        prog[6] = enc_sw(5'd9, 5'd0, 12'h30);
        prog[7] = enc_sw(5'd5, 5'd0, 12'h34);
        run_test("minstret", 8, 1'b0, 1'b0);

        load_base();
        prog[0] = enc_addi(5'd1, 5'd0, 12'd11);
        prog[1] = enc_sw(5'd1, 5'd0, 12'h40);
        prog[2] = 32'hffff_ffff;
        prog[3] = enc_addi(5'd2, 5'd0, 12'd22);
        prog[4] = enc_sw(5'd2, 5'd0, 12'h44);
        patch_addr = 32'd8;
        run_test("illegal", 5, 1'b0, 1'b0);
        load_base();
        prog[0] = enc_addi(5'd1, 5'd0, 12'd11);
        prog[1] = enc_sw(5'd1, 5'd0, 12'h40);
        prog[2] = 32'hffff_ffff;
        prog[3] = enc_addi(5'd2, 5'd0, 12'd22);
        prog[4] = enc_sw(5'd2, 5'd0, 12'h44);
        patch_addr = 32'd8;
        run_test("illegal_gap", 5, 1'b1, 1'b0);

        load_arith();
        run_test("ext_irq", 18, 1'b0, 1'b1);

        $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* mini_rv_core.f */
+incdir+include
hdl/core_pkg.sv
hdl/fetch_decode.sv
hdl/reg_file.sv
hdl/execute_unit.sv
hdl/trap_ctrl.sv
hdl/retire_counter.sv
hdl/core_top.sv
dv/core_sva.sv
dv/core_tb.sv
